/* design/credit_counter.sv */
// Saturating credit count that starts full after reset
// Take and give in the same cycle cancel out
`timescale 1ns/1ps

module credit_counter #(
    parameter int num_credits = 4
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic credit_take_i,
    input  logic credit_give_i,
    output logic credit_left_o
);

    // Wide enough to hold the full count
    localparam int cnt_width = $clog2(num_credits + 1);

    logic [cnt_width-1:0] count_q;
    logic                 cnt_empty;
    logic                 cnt_full;

    assign cnt_empty = (count_q == '0);
    assign cnt_full  = (count_q == cnt_width'(num_credits));

    // ####################
    // Count update
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // All slots free out of reset
            count_q <= cnt_width'(num_credits);
        end else if (credit_take_i && !credit_give_i) begin
            // Saturate at zero
            if (!cnt_empty) begin
                count_q <= count_q - 1'b1;
            end
        end else if (credit_give_i && !credit_take_i) begin
            // Saturate at the full count
            if (!cnt_full) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Room for at least one more fetch
    assign credit_left_o = !cnt_empty;

endmodule

/* design/exec_pipe.sv */
// Stand-in for a fixed-latency functional unit, never stalls
// Latency must be at least 1, one instruction may enter per cycle
`timescale 1ns/1ps

module exec_pipe #(
    parameter int exec_latency = 3
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            issue_valid_i,
    input  logic            issue_ready_i,
    input  issue_pkg::tag_t issue_tag_i,
    output logic            done_valid_o,
    output issue_pkg::tag_t done_tag_o
);

    logic [exec_latency-1:0]                valid_q;
    issue_pkg::tag_t [exec_latency-1:0]     tag_q;
    logic                                   issue_fire;

    // Snooped dispatch handshake
    assign issue_fire = issue_valid_i && issue_ready_i;

    // ####################
    // Stage chain
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= issue_fire;
            for (int s = 1; s < exec_latency; s++) begin
                valid_q[s] <= valid_q[s-1];
            end
        end
    end

    // Tags move alongside their valid bits
    always_ff @(posedge clk_i) begin
        tag_q[0] <= issue_tag_i;
        for (int s = 1; s < exec_latency; s++) begin
            tag_q[s] <= tag_q[s-1];
        end
    end

    // Last stage is the completion broadcast
    assign done_valid_o = valid_q[exec_latency-1];
    assign done_tag_o   = tag_q[exec_latency-1];

endmodule

/* design/issue_pkg.sv */
// Widths and payload types shared by every block of the issue slice
// Tags must be unique among all instructions in flight at the same time
package issue_pkg;

    // ####################
    // Base widths
    // ####################

    // Program counter width
    localparam int pc_width = 32;
    // Threads per warp, one mask bit each
    localparam int warp_width = 32;
    // Architectural register index width
    localparam int reg_idx_width = 6;

    // Distinct result tags in flight
    localparam int num_tags = 8;
    // Tag width follows from the tag count
    localparam int tag_width = $clog2(num_tags);

    // Source operands per instruction
    localparam int operands_per_inst = 2;

    // ####################
    // Payload types
    // ####################

    typedef logic [pc_width-1:0] pc_t;

    // One bit per thread of the warp
    typedef logic [warp_width-1:0] act_mask_t;

    typedef logic [reg_idx_width-1:0] reg_idx_t;

    // Producer and result tag
    typedef logic [tag_width-1:0] tag_t;

endpackage

/* design/issue_slice.sv */
// Single-warp issue slice closed by a fixed-latency execution pipe
// All wakeups come from the internal pipe, completion is exec_latency after dispatch
`timescale 1ns/1ps

module issue_slice #(
    parameter int wb_depth     = 4,
    parameter int exec_latency = 3
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Fetch side
    input  logic                fe_handshake_i,
    output logic                ib_space_available_o,

    // Decode side
    output logic                wb_ready_o,
    input  logic                dec_valid_i,
    input  issue_pkg::pc_t      dec_pc_i,
    input  issue_pkg::act_mask_t dec_act_mask_i,
    input  issue_pkg::tag_t     dec_tag_i,
    input  issue_pkg::reg_idx_t dec_dst_reg_i,
    input  logic [issue_pkg::operands_per_inst-1:0] dec_operands_ready_i,
    input  issue_pkg::tag_t [issue_pkg::operands_per_inst-1:0] dec_operand_tags_i,
    input  issue_pkg::reg_idx_t [issue_pkg::operands_per_inst-1:0] dec_operands_i,

    // Dispatch side
    input  logic                opc_ready_i,
    output logic                disp_valid_o,
    output issue_pkg::tag_t     disp_tag_o,
    output issue_pkg::pc_t      disp_pc_o,
    output issue_pkg::act_mask_t disp_act_mask_o,
    output issue_pkg::reg_idx_t disp_dst_o,
    output issue_pkg::reg_idx_t [issue_pkg::operands_per_inst-1:0] disp_operands_o,

    // Completion broadcast
    output logic                wb_valid_o,
    output issue_pkg::tag_t     wb_tag_o
);

    wait_buffer #(
        .wb_depth(wb_depth)
    ) u_wait_buffer (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .fe_handshake_i      (fe_handshake_i),
        .ib_space_available_o(ib_space_available_o),
        .wb_ready_o          (wb_ready_o),
        .dec_valid_i         (dec_valid_i),
        .dec_pc_i            (dec_pc_i),
        .dec_act_mask_i      (dec_act_mask_i),
        .dec_tag_i           (dec_tag_i),
        .dec_dst_reg_i       (dec_dst_reg_i),
        .dec_operands_ready_i(dec_operands_ready_i),
        .dec_operand_tags_i  (dec_operand_tags_i),
        .dec_operands_i      (dec_operands_i),
        // Wakeup fed back from the pipe
        .wb_valid_i          (wb_valid_o),
        .wb_tag_i            (wb_tag_o),
        .opc_ready_i         (opc_ready_i),
        .disp_valid_o        (disp_valid_o),
        .disp_tag_o          (disp_tag_o),
        .disp_pc_o           (disp_pc_o),
        .disp_act_mask_o     (disp_act_mask_o),
        .disp_dst_o          (disp_dst_o),
        .disp_operands_o     (disp_operands_o)
    );

    // Pipe watches the dispatch handshake directly
    exec_pipe #(
        .exec_latency(exec_latency)
    ) u_exec_pipe (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .issue_valid_i(disp_valid_o),
        .issue_ready_i(opc_ready_i),
        .issue_tag_i  (disp_tag_o),
        .done_valid_o (wb_valid_o),
        .done_tag_o   (wb_tag_o)
    );

endmodule

/* design/rr_arbiter.sv */
// Round-robin arbiter, first request at or after a rotating pointer wins
// A grant stalled downstream stays locked, so its requester must keep requesting
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int num_req = 4
) (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic [num_req-1:0] req_i,
    input  logic               stall_i,
    output logic [num_req-1:0] gnt_o,
    output logic               valid_o
);

    localparam int idx_width = (num_req > 1) ? $clog2(num_req) : 1;

    logic [idx_width-1:0] ptr_q;
    logic                 lock_q;
    logic [num_req-1:0]   gnt_q;
    logic [num_req-1:0]   rr_gnt;
    logic [idx_width-1:0] win_idx;

    // ####################
    // Fresh choice
    // ####################

    // Scan from far to near so the closest request to the pointer wins
    always_comb begin : rr_pick
        int cand;
        rr_gnt = '0;
        for (int off = num_req - 1; off >= 0; off--) begin
            cand = (int'(ptr_q) + off) % num_req;
            if (req_i[cand]) begin
                rr_gnt       = '0;
                rr_gnt[cand] = 1'b1;
            end
        end
    end

    // Locked grant wins over a new choice
    assign gnt_o   = lock_q ? gnt_q : rr_gnt;
    assign valid_o = |gnt_o;

    // Index of the granted requester
    always_comb begin
        win_idx = '0;
        for (int i = 0; i < num_req; i++) begin
            if (gnt_o[i]) begin
                win_idx = idx_width'(i);
            end
        end
    end

    // ####################
    // State
    // ####################

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ptr_q  <= '0;
            lock_q <= 1'b0;
            gnt_q  <= '0;
        end else begin
            // Hold the grant across stalled cycles
            lock_q <= valid_o && stall_i;
            gnt_q  <= gnt_o;
            // Accepted grant, so the winner drops to lowest priority
            if (valid_o && !stall_i) begin
                ptr_q <= idx_width'((int'(win_idx) + 1) % num_req);
            end
        end
    end

endmodule

/* design/wait_buffer.sv */
// Single-warp wait buffer, holds decoded instructions until their operands are ready
// Decode is accepted only while a slot is free, the fetcher is throttled by credits
`timescale 1ns/1ps

module wait_buffer #(
    parameter int wb_depth = 4
) (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // Fetch side
    input  logic                fe_handshake_i,
    output logic                ib_space_available_o,

    // Decode side
    output logic                wb_ready_o,
    input  logic                dec_valid_i,
    input  issue_pkg::pc_t      dec_pc_i,
    input  issue_pkg::act_mask_t dec_act_mask_i,
    input  issue_pkg::tag_t     dec_tag_i,
    input  issue_pkg::reg_idx_t dec_dst_reg_i,
    input  logic [issue_pkg::operands_per_inst-1:0] dec_operands_ready_i,
    input  issue_pkg::tag_t [issue_pkg::operands_per_inst-1:0] dec_operand_tags_i,
    input  issue_pkg::reg_idx_t [issue_pkg::operands_per_inst-1:0] dec_operands_i,

    // Completion broadcast
    input  logic                wb_valid_i,
    input  issue_pkg::tag_t     wb_tag_i,

    // Dispatch toward the operand collector
    input  logic                opc_ready_i,
    output logic                disp_valid_o,
    output issue_pkg::tag_t     disp_tag_o,
    output issue_pkg::pc_t      disp_pc_o,
    output issue_pkg::act_mask_t disp_act_mask_o,
    output issue_pkg::reg_idx_t disp_dst_o,
    output issue_pkg::reg_idx_t [issue_pkg::operands_per_inst-1:0] disp_operands_o
);

    localparam int n_ops = issue_pkg::operands_per_inst;

    // ####################
    // Entry storage
    // ####################

    logic [wb_depth-1:0]  valid_q;
    issue_pkg::pc_t       pc_q       [wb_depth];
    issue_pkg::act_mask_t mask_q     [wb_depth];
    issue_pkg::tag_t      tag_q      [wb_depth];
    issue_pkg::reg_idx_t  dst_q      [wb_depth];
    logic [n_ops-1:0]     rdy_q      [wb_depth];
    issue_pkg::tag_t     [n_ops-1:0] op_tag_q [wb_depth];
    issue_pkg::reg_idx_t [n_ops-1:0] op_reg_q [wb_depth];

    logic [wb_depth-1:0] insert_sel;
    logic [wb_depth-1:0] entry_req;
    logic [wb_depth-1:0] arb_gnt;
    logic                insert_fire;
    logic                disp_fire;

    assign wb_ready_o  = !(&valid_q);
    assign insert_fire = dec_valid_i && wb_ready_o;
    assign disp_fire   = disp_valid_o && opc_ready_i;

    // One credit per fetched instruction, returned at dispatch
    credit_counter #(
        .num_credits(wb_depth)
    ) u_credit_counter (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .credit_take_i(fe_handshake_i),
        .credit_give_i(disp_fire),
        .credit_left_o(ib_space_available_o)
    );

    // Lowest free slot takes the next insert
    always_comb begin : pick_free
        logic found;
        found      = 1'b0;
        insert_sel = '0;
        for (int e = 0; e < wb_depth; e++) begin
            if (!valid_q[e] && !found) begin
                insert_sel[e] = 1'b1;
                found         = 1'b1;
            end
        end
    end

    // ####################
    // Insert and wakeup
    // ####################

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < wb_depth; e++) begin
            if (insert_fire && insert_sel[e]) begin
                pc_q[e]     <= dec_pc_i;
                mask_q[e]   <= dec_act_mask_i;
                tag_q[e]    <= dec_tag_i;
                dst_q[e]    <= dec_dst_reg_i;
                op_tag_q[e] <= dec_operand_tags_i;
                op_reg_q[e] <= dec_operands_i;
                // Completion in the insert cycle also counts
                for (int op = 0; op < n_ops; op++) begin
                    rdy_q[e][op] <= dec_operands_ready_i[op]
                                 || (wb_valid_i && dec_operand_tags_i[op] == wb_tag_i);
                end
            end else begin
                // Wake pending operands on a matching tag
                for (int op = 0; op < n_ops; op++) begin
                    if (wb_valid_i && op_tag_q[e][op] == wb_tag_i) begin
                        rdy_q[e][op] <= 1'b1;
                    end
                end
            end
        end
    end

    // Set on insert, cleared on dispatch handshake
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= (valid_q & ~(disp_fire ? arb_gnt : '0))
                     | (insert_fire ? insert_sel : '0);
        end
    end

    // ####################
    // Dispatch
    // ####################

    // Valid entry with every operand ready
    always_comb begin
        for (int e = 0; e < wb_depth; e++) begin
            entry_req[e] = valid_q[e] && (&rdy_q[e]);
        end
    end

    rr_arbiter #(
        .num_req(wb_depth)
    ) u_rr_arbiter (
        .clk_i  (clk_i),
        .rst_n_i(rst_n_i),
        .req_i  (entry_req),
        .stall_i(!opc_ready_i),
        .gnt_o  (arb_gnt),
        .valid_o(disp_valid_o)
    );

    // One-hot payload mux
    always_comb begin
        disp_tag_o      = '0;
        disp_pc_o       = '0;
        disp_act_mask_o = '0;
        disp_dst_o      = '0;
        disp_operands_o = '0;
        for (int e = 0; e < wb_depth; e++) begin
            if (arb_gnt[e]) begin
                disp_tag_o      = tag_q[e];
                disp_pc_o       = pc_q[e];
                disp_act_mask_o = mask_q[e];
                disp_dst_o      = dst_q[e];
                disp_operands_o = op_reg_q[e];
            end
        end
    end

endmodule

/* list.f */
+incdir+verification
design/issue_pkg.sv
design/credit_counter.sv
design/rr_arbiter.sv
design/wait_buffer.sv
design/exec_pipe.sv
design/issue_slice.sv
verification/tb_issue_slice.sv

/* run.sh */
#!/bin/sh
# Builds the issue slice testbench with Verilator and runs it
# The exit status of the simulation decides pass or fail
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_issue_slice \
    -f list.f \
    -o tb_issue_slice

./obj_dir/tb_issue_slice

/* verification/tb_lfsr.svh */
// Galois LFSR stimulus source, included inside the testbench module
// Every random bit costs one LFSR step
`ifndef TB_LFSR_SVH
`define TB_LFSR_SVH

// Shared LFSR state, starts from the fixed seed
logic [15:0] lfsr_state = 16'd82;

// One Galois step, taps of a maximal 16-bit sequence
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ 16'hB400;
    end
    return n;
endfunction

// Next n bits, MSB first
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

// Word aligned program counter
function automatic issue_pkg::pc_t rand_pc();
    return rand_bits(32) & ~32'h3;
endfunction

function automatic issue_pkg::reg_idx_t rand_reg();
    return issue_pkg::reg_idx_t'(rand_bits(6));
endfunction

function automatic issue_pkg::tag_t rand_tag();
    return issue_pkg::tag_t'(rand_bits(3));
endfunction

`endif

/* verification/tb_issue_slice.sv */
// Testbench for the issue slice with wb_depth 4 and exec_latency 3
// Tags are assigned here and stay unique while in flight
`timescale 1ns/1ps

module tb_issue_slice;

    localparam int wb_depth     = 4;
    localparam int exec_latency = 3;
    localparam int n_tags       = issue_pkg::num_tags;
    localparam int n_ops        = issue_pkg::operands_per_inst;
    localparam int wait_limit   = 200;

    logic                 clk_i = 1'b0;
    logic                 rst_n_i = 1'b0;
    logic                 fe_handshake_i = 1'b0;
    logic                 ib_space_available_o;
    logic                 wb_ready_o;
    logic                 dec_valid_i = 1'b0;
    issue_pkg::pc_t       dec_pc_i = '0;
    issue_pkg::act_mask_t dec_act_mask_i = '0;
    issue_pkg::tag_t      dec_tag_i = '0;
    issue_pkg::reg_idx_t  dec_dst_reg_i = '0;
    logic [n_ops-1:0]     dec_operands_ready_i = '0;
    issue_pkg::tag_t [n_ops-1:0]     dec_operand_tags_i = '0;
    issue_pkg::reg_idx_t [n_ops-1:0] dec_operands_i = '0;
    logic                 opc_ready_i = 1'b0;
    logic                 disp_valid_o;
    issue_pkg::tag_t      disp_tag_o;
    issue_pkg::pc_t       disp_pc_o;
    issue_pkg::act_mask_t disp_act_mask_o;
    issue_pkg::reg_idx_t  disp_dst_o;
    issue_pkg::reg_idx_t [n_ops-1:0] disp_operands_o;
    logic                 wb_valid_o;
    issue_pkg::tag_t      wb_tag_o;

    `include "tb_lfsr.svh"

    // Reference record per tag, state 0 free, 1 waiting, 2 executing
    int                   tag_state [n_tags] = '{default: 0};
    issue_pkg::pc_t       exp_pc    [n_tags];
    issue_pkg::act_mask_t exp_mask  [n_tags];
    issue_pkg::reg_idx_t  exp_dst   [n_tags];
    issue_pkg::reg_idx_t [n_ops-1:0] exp_ops [n_tags];
    issue_pkg::tag_t [n_ops-1:0]     dep_tag [n_tags];
    // Producers not yet seen on the completion bus
    logic [n_ops-1:0]     dep_pending [n_tags];
    // Completions owed, in dispatch order
    issue_pkg::tag_t      done_tag_q [$];
    int                   done_cyc_q [$];

    int cyc = 0;
    int credits = wb_depth;
    int occupancy = 0;
    // 0 random, 1 held low, 2 held high
    int bp_mode = 1;

    // Dispatch snapshot of a stalled cycle
    logic                 held_q = 1'b0;
    issue_pkg::tag_t      held_tag;
    issue_pkg::pc_t       held_pc;
    issue_pkg::act_mask_t held_mask;
    issue_pkg::reg_idx_t  held_dst;
    issue_pkg::reg_idx_t [n_ops-1:0] held_ops;

    always #2 clk_i = ~clk_i;

    issue_slice #(
        .wb_depth    (wb_depth),
        .exec_latency(exec_latency)
    ) u_issue_slice (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .fe_handshake_i(fe_handshake_i), .ib_space_available_o(ib_space_available_o),
        .wb_ready_o(wb_ready_o), .dec_valid_i(dec_valid_i), .dec_pc_i(dec_pc_i),
        .dec_act_mask_i(dec_act_mask_i), .dec_tag_i(dec_tag_i),
        .dec_dst_reg_i(dec_dst_reg_i), .dec_operands_ready_i(dec_operands_ready_i),
        .dec_operand_tags_i(dec_operand_tags_i), .dec_operands_i(dec_operands_i),
        .opc_ready_i(opc_ready_i), .disp_valid_o(disp_valid_o), .disp_tag_o(disp_tag_o),
        .disp_pc_o(disp_pc_o), .disp_act_mask_o(disp_act_mask_o), .disp_dst_o(disp_dst_o),
        .disp_operands_o(disp_operands_o), .wb_valid_o(wb_valid_o), .wb_tag_o(wb_tag_o)
    );

    // ####################
    // Failure reporting
    // ####################

    task automatic stop_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failing check");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                   input logic [63:0] act_val);
        $display("Mismatch at %0t ns: %s expected %0h, actual %0h",
                 $time, name, exp_val, act_val);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        stop_run();
    endtask

    // ####################
    // Checking at the rising edge
    // ####################

    always @(posedge clk_i) begin : check_outputs
        issue_pkg::tag_t t;
        if (!rst_n_i) begin
            held_q = 1'b0;
        end else begin
            cyc++;
            // Status outputs follow registered occupancy and credits
            assert (wb_ready_o == (occupancy < wb_depth))
                else report_mismatch("wb_ready_o", 64'(occupancy < wb_depth), 64'(wb_ready_o));
            assert (ib_space_available_o == (credits > 0))
                else report_mismatch("ib_space_available_o", 64'(credits > 0),
                                     64'(ib_space_available_o));
            assert (occupancy != 0 || !disp_valid_o)
                else report_failure("dispatch offered while the buffer is empty");
            // Stalled offer must not move
            if (held_q) begin
                assert (disp_valid_o) else report_mismatch("disp_valid_o", 64'(1), 64'(0));
                assert (disp_tag_o == held_tag)
                    else report_mismatch("disp_tag_o", 64'(held_tag), 64'(disp_tag_o));
                assert (disp_pc_o == held_pc)
                    else report_mismatch("disp_pc_o", 64'(held_pc), 64'(disp_pc_o));
                assert (disp_act_mask_o == held_mask)
                    else report_mismatch("disp_act_mask_o", 64'(held_mask),
                                         64'(disp_act_mask_o));
                assert (disp_dst_o == held_dst)
                    else report_mismatch("disp_dst_o", 64'(held_dst), 64'(disp_dst_o));
                assert (disp_operands_o == held_ops)
                    else report_mismatch("disp_operands_o", 64'(held_ops),
                                         64'(disp_operands_o));
            end
            // Dispatch handshake against the record of its tag
            if (disp_valid_o && opc_ready_i) begin
                t = disp_tag_o;
                assert (tag_state[t] == 1) else report_failure(
                    $sformatf("tag %0d dispatched while not waiting in the buffer", t));
                assert (dep_pending[t] == '0) else report_failure(
                    $sformatf("tag %0d dispatched before its producer completed", t));
                assert (disp_pc_o == exp_pc[t])
                    else report_mismatch("disp_pc_o", 64'(exp_pc[t]), 64'(disp_pc_o));
                assert (disp_act_mask_o == exp_mask[t])
                    else report_mismatch("disp_act_mask_o", 64'(exp_mask[t]),
                                         64'(disp_act_mask_o));
                assert (disp_dst_o == exp_dst[t])
                    else report_mismatch("disp_dst_o", 64'(exp_dst[t]), 64'(disp_dst_o));
                assert (disp_operands_o == exp_ops[t])
                    else report_mismatch("disp_operands_o", 64'(exp_ops[t]),
                                         64'(disp_operands_o));
                tag_state[t] = 2;
                done_tag_q.push_back(t);
                done_cyc_q.push_back(cyc + exec_latency);
            end
            // Completion due this cycle, otherwise the bus stays idle
            if (done_cyc_q.size() != 0 && done_cyc_q[0] == cyc) begin
                assert (wb_valid_o) else report_failure(
                    $sformatf("completion of tag %0d did not appear on time", done_tag_q[0]));
                assert (wb_tag_o == done_tag_q[0])
                    else report_mismatch("wb_tag_o", 64'(done_tag_q[0]), 64'(wb_tag_o));
                t = done_tag_q.pop_front();
                void'(done_cyc_q.pop_front());
                tag_state[t] = 0;
                for (int i = 0; i < n_tags; i++) begin
                    for (int k = 0; k < n_ops; k++) begin
                        if (dep_tag[i][k] == t) begin
                            dep_pending[i][k] = 1'b0;
                        end
                    end
                end
            end else begin
                assert (!wb_valid_o) else report_failure("completion without a matching dispatch");
            end
            // Model state after this edge
            if (fe_handshake_i) credits--;
            if (dec_valid_i && wb_ready_o) occupancy++;
            if (disp_valid_o && opc_ready_i) begin
                credits++;
                occupancy--;
            end
            held_q    = disp_valid_o && !opc_ready_i;
            held_tag  = disp_tag_o;
            held_pc   = disp_pc_o;
            held_mask = disp_act_mask_o;
            held_dst  = disp_dst_o;
            held_ops  = disp_operands_o;
        end
    end

    // ####################
    // Stimulus
    // ####################

    // Falling edge, pulses drop and the dispatch ready follows bp_mode
    task automatic next_cycle();
        @(negedge clk_i);
        fe_handshake_i = 1'b0;
        dec_valid_i    = 1'b0;
        if (bp_mode == 0) opc_ready_i = (rand_bits(2) != 0);
        else opc_ready_i = (bp_mode == 2);
    endtask

    task automatic wait_for_credit();
        int n;
        n = 0;
        while (!ib_space_available_o && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!ib_space_available_o) report_failure("timeout waiting for a fetch credit");
    endtask

    task automatic wait_for_room();
        int n;
        n = 0;
        while (!wb_ready_o && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!wb_ready_o) report_failure("timeout waiting for a free buffer slot");
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while ((occupancy != 0 || done_tag_q.size() != 0) && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (occupancy != 0 || done_tag_q.size() != 0)
            report_failure("timeout waiting for the buffer and pipe to drain");
    endtask

    // Free tag, or one still in flight, from a random start
    task automatic find_tag(input logic busy, output issue_pkg::tag_t t, output logic found);
        int start;
        int cand;
        start = int'(rand_bits(3));
        found = 1'b0;
        t     = '0;
        for (int off = 0; off < n_tags; off++) begin
            cand = (start + off) % n_tags;
            if (!found && ((tag_state[cand] != 0) == busy)) begin
                t     = issue_pkg::tag_t'(cand);
                found = 1'b1;
            end
        end
    endtask

    // Fetch pulse, then one decoded instruction with fresh tag and random deps
    task automatic issue_instr(input logic all_ready);
        issue_pkg::tag_t t;
        issue_pkg::tag_t p;
        logic            found;
        wait_for_credit();
        fe_handshake_i = 1'b1;
        next_cycle();
        if (rand_bits(1) != 0) next_cycle();
        wait_for_room();
        find_tag(1'b0, t, found);
        if (!found) report_failure("no free tag left to assign");
        exp_pc[t]   = rand_pc();
        exp_mask[t] = rand_bits(32);
        exp_dst[t]  = rand_reg();
        for (int k = 0; k < n_ops; k++) begin
            exp_ops[t][k]     = rand_reg();
            dep_tag[t][k]     = rand_tag();
            dep_pending[t][k] = 1'b0;
            if (!all_ready && rand_bits(1) != 0) begin
                find_tag(1'b1, p, found);
                if (found) begin
                    dep_tag[t][k]     = p;
                    dep_pending[t][k] = 1'b1;
                end
            end
        end
        tag_state[t] = 1;
        dec_valid_i          = 1'b1;
        dec_pc_i             = exp_pc[t];
        dec_act_mask_i       = exp_mask[t];
        dec_tag_i            = t;
        dec_dst_reg_i        = exp_dst[t];
        dec_operands_ready_i = ~dep_pending[t];
        dec_operand_tags_i   = dep_tag[t];
        dec_operands_i       = exp_ops[t];
        next_cycle();
    endtask

    initial begin : stimulus
        repeat (3) @(posedge clk_i);
        next_cycle();
        rst_n_i = 1'b1;
        // Fill the buffer with dispatch blocked
        for (int i = 0; i < wb_depth; i++) issue_instr(1'b1);
        assert (!ib_space_available_o)
            else report_mismatch("ib_space_available_o", 64'(0), 64'(ib_space_available_o));
        assert (!wb_ready_o) else report_mismatch("wb_ready_o", 64'(0), 64'(wb_ready_o));
        repeat (4) next_cycle();
        // Random traffic with dependencies and random back-pressure
        bp_mode = 0;
        for (int i = 0; i < 60; i++) issue_instr(1'b0);
        bp_mode = 2;
        wait_idle();
        $display("all tests passed");
        $finish;
    end

endmodule
